// ==== Makefile ====
# Verilator build and run of the cpu testbench
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# The log decides the result, the run's own exit status is not used
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
logic/cpuPkg.sv
logic/fetch.sv
logic/registerFile.sv
logic/decode.sv
logic/hazardUnit.sv
logic/cpu.sv
verification/cpuTb.sv

// ==== logic/cpu.sv ====
`default_nettype none

module cpu (
  input  wire                clk,
  input  wire                rstN,
  input  wire cpuPkg::word_t instr,
  input  wire cpuPkg::word_t memReadData,
  output cpuPkg::word_t      pc,
  output cpuPkg::word_t      memAddr,
  output cpuPkg::word_t      memWriteData,
  output logic               memEnable,
  output logic               memWrite,
  output logic               hlt
);

  cpuPkg::ifIdReg_t  ifId;
  cpuPkg::idExReg_t  idEx;
  cpuPkg::idExReg_t  idExNext;
  cpuPkg::exMemReg_t exMem;
  cpuPkg::memWbReg_t memWb;
  cpuPkg::flags_t    flags;

  cpuPkg::word_t   pcNext;
  cpuPkg::word_t   branchTarget;
  cpuPkg::regIdx_t src1;
  cpuPkg::regIdx_t src2;
  logic            storeSrc;
  logic            isBranch;
  logic            branchTaken;
  logic            decodeHlt;
  logic            haltSeen;
  logic            pcStall;
  logic            ifIdStall;
  logic            ifFlush;
  logic            idFlush;

  logic            wbEn;
  cpuPkg::word_t   wbData;

  assign wbEn   = memWb.wb.regWrite;
  // Loaded data, PCS return address or ALU result
  assign wbData = memWb.wb.memToReg ? memWb.memData :
                  memWb.wb.pcs      ? memWb.pcNext  : memWb.aluOut;

  //////////////////////////////
  // Hazards
  //////////////////////////////
  hazardUnit i_hazardUnit (
    .src1        (src1),
    .src2        (src2),
    .storeSrc    (storeSrc),
    .isBranch    (isBranch),
    .branchTaken (branchTaken),
    .idExWb      (idEx.wb),
    .idExMem     (idEx.mem),
    .idExZEn     (idEx.ex.zEn),
    .idExNvEn    (idEx.ex.nvEn),
    .pcStall     (pcStall),
    .ifIdStall   (ifIdStall),
    .ifFlush     (ifFlush),
    .idFlush     (idFlush)
  );

  //////////////////////////////
  // Fetch
  //////////////////////////////
  fetch i_fetch (
    .clk          (clk),
    .rstN         (rstN),
    .pcStall      (pcStall),
    .decodeHlt    (decodeHlt),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .pc           (pc),
    .pcNext       (pcNext)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ifId     <= '0;
      haltSeen <= 1'b0;
    end else begin
      if (decodeHlt) haltSeen <= 1'b1;
      if (!ifIdStall) begin
        if (ifFlush || decodeHlt || haltSeen) ifId <= '0;
        else ifId <= '{instr: instr, pcNext: pcNext, valid: 1'b1};
      end
    end
  end

  //////////////////////////////
  // Decode
  //////////////////////////////
  decode i_decode (
    .clk          (clk),
    .rstN         (rstN),
    .ifId         (ifId),
    .flags        (flags),
    .wbEn         (wbEn),
    .wbRd         (memWb.wb.rd),
    .wbData       (wbData),
    .idExNext     (idExNext),
    .isBranch     (isBranch),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .decodeHlt    (decodeHlt),
    .src1         (src1),
    .src2         (src2),
    .storeSrc     (storeSrc)
  );

  always_ff @(posedge clk) begin
    if (!rstN || idFlush) idEx <= '0;
    else idEx <= idExNext;
  end

  //////////////////////////////
  // Execute
  //////////////////////////////
  function automatic cpuPkg::word_t fwd(input cpuPkg::regIdx_t src,
                                        input cpuPkg::word_t   dflt);
    if (src == '0) return dflt;
    if (exMem.wb.regWrite && !exMem.wb.memToReg && (exMem.wb.rd == src))
      return exMem.aluOut;
    if (memWb.wb.regWrite && (memWb.wb.rd == src)) return wbData;
    return dflt;
  endfunction

  cpuPkg::word_t  opA;
  cpuPkg::word_t  opB;
  cpuPkg::word_t  storeFwd;
  cpuPkg::word_t  aluOut;
  cpuPkg::flags_t aluFlags;

  always_comb begin
    logic [16:0] sum;
    logic        ovf;
    opA      = fwd(idEx.ex.src1, idEx.ex.opA);
    opB      = idEx.ex.useImm ? idEx.ex.imm : fwd(idEx.ex.src2, idEx.ex.opB);
    storeFwd = fwd(idEx.ex.src2, idEx.mem.storeData);
    ovf      = 1'b0;
    sum      = '0;
    case (idEx.ex.aluOp)
      cpuPkg::ALU_ADD: begin
        sum    = {opA[15], opA} + {opB[15], opB};
        ovf    = (opA[15] == opB[15]) && (sum[15] != opA[15]);
        aluOut = ovf ? (opA[15] ? 16'h8000 : 16'h7FFF) : sum[15:0];
      end
      cpuPkg::ALU_SUB: begin
        sum    = {opA[15], opA} - {opB[15], opB};
        ovf    = (opA[15] != opB[15]) && (sum[15] != opA[15]);
        aluOut = ovf ? (opA[15] ? 16'h8000 : 16'h7FFF) : sum[15:0];
      end
      cpuPkg::ALU_XOR: aluOut = opA ^ opB;
      default:         aluOut = {opB[15:8], opB[7:0] | opA[7:0]};
    endcase
    aluFlags.z = (aluOut == '0);
    aluFlags.n = aluOut[15];
    aluFlags.v = ovf;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
      exMem <= '0;
    end else begin
      if (idEx.ex.zEn)  flags.z <= aluFlags.z;
      if (idEx.ex.nvEn) begin
        flags.n <= aluFlags.n;
        flags.v <= aluFlags.v;
      end
      exMem.aluOut        <= aluOut;
      exMem.mem           <= idEx.mem;
      exMem.mem.storeData <= storeFwd;
      exMem.wb            <= idEx.wb;
      exMem.pcNext        <= idEx.pcNext;
    end
  end

  //////////////////////////////
  // Memory
  //////////////////////////////
  assign memAddr   = exMem.aluOut;
  assign memEnable = exMem.mem.memEnable;
  assign memWrite  = exMem.mem.memWrite;

  always_comb begin
    memWriteData = exMem.mem.storeData;
    if (exMem.mem.memWrite && memWb.wb.regWrite && (memWb.wb.rd != '0) &&
        (memWb.wb.rd == exMem.wb.rd)) begin
      memWriteData = wbData;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWb <= '0;
      hlt   <= 1'b0;
    end else begin
      memWb.aluOut  <= exMem.aluOut;
      memWb.memData <= memReadData;
      memWb.pcNext  <= exMem.pcNext;
      memWb.wb      <= exMem.wb;
      if (exMem.wb.hlt) hlt <= 1'b1; // Rises as HLT enters MEM/WB
    end
  end

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  //////////////////////////////
  // Basic widths
  //////////////////////////////
  typedef logic [15:0] word_t;   // Data or address word
  typedef logic [3:0]  regIdx_t; // Register index, r0 reads zero
  typedef logic [3:0]  opcode_t; // Instruction bits [15:12]
  typedef logic [2:0]  cond_t;   // Branch condition bits [11:9]
  typedef logic [1:0]  fwdSel_t; // EX operand source
  typedef logic [1:0]  aluOp_t;  // ALU function

  // Opcodes
  localparam opcode_t OP_ADD = 4'h0;
  localparam opcode_t OP_SUB = 4'h1;
  localparam opcode_t OP_XOR = 4'h2;
  localparam opcode_t OP_LW  = 4'h8;
  localparam opcode_t OP_SW  = 4'h9;
  localparam opcode_t OP_LLB = 4'hA;
  localparam opcode_t OP_LHB = 4'hB;
  localparam opcode_t OP_B   = 4'hC;
  localparam opcode_t OP_PCS = 4'hE;
  localparam opcode_t OP_HLT = 4'hF;

  // Branch conditions
  localparam cond_t CC_NE  = 3'b000; // Z=0
  localparam cond_t CC_EQ  = 3'b001; // Z=1
  localparam cond_t CC_GT  = 3'b010; // Z=0 and N=0
  localparam cond_t CC_LT  = 3'b011; // N=1
  localparam cond_t CC_GE  = 3'b100;
  localparam cond_t CC_LE  = 3'b101;
  localparam cond_t CC_OVF = 3'b110; // V=1
  localparam cond_t CC_UN  = 3'b111; // Always taken

  localparam fwdSel_t FWD_NONE  = 2'd0; // Value read in decode
  localparam fwdSel_t FWD_EXMEM = 2'd1; // ALU result one stage ahead
  localparam fwdSel_t FWD_MEMWB = 2'd2; // Write-back data

  localparam aluOp_t ALU_ADD  = 2'd0;
  localparam aluOp_t ALU_SUB  = 2'd1;
  localparam aluOp_t ALU_XOR  = 2'd2;
  localparam aluOp_t ALU_PASS = 2'd3; // Immediate with low byte merge

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  //////////////////////////////
  // Pipeline registers
  //////////////////////////////
  typedef struct packed {
    word_t instr;
    word_t pcNext;
    logic  valid;
  } ifIdReg_t;

  typedef struct packed {
    regIdx_t src1;   // Forwarding compare keys
    regIdx_t src2;
    word_t   opA;
    word_t   opB;
    word_t   imm;
    aluOp_t  aluOp;
    logic    useImm; // Second operand is imm
    logic    zEn;
    logic    nvEn;
  } exCtrl_t;

  typedef struct packed {
    logic  memEnable;
    logic  memWrite;
    word_t storeData;
  } memCtrl_t;

  typedef struct packed {
    regIdx_t rd;       // Holds rt for SW with regWrite low
    logic    regWrite;
    logic    memToReg;
    logic    pcs;
    logic    hlt;
  } wbCtrl_t;

  typedef struct packed {
    exCtrl_t  ex;
    memCtrl_t mem;
    wbCtrl_t  wb;
    word_t    pcNext;
  } idExReg_t;

  typedef struct packed {
    word_t    aluOut;
    memCtrl_t mem;
    wbCtrl_t  wb;
    word_t    pcNext;
  } exMemReg_t;

  typedef struct packed {
    word_t   aluOut;
    word_t   memData;
    word_t   pcNext;
    wbCtrl_t wb;
  } memWbReg_t;

endpackage

`default_nettype wire

// ==== logic/decode.sv ====
`default_nettype none

module decode (
  input  wire                   clk,
  input  wire                   rstN,
  input  wire cpuPkg::ifIdReg_t ifId,
  input  wire cpuPkg::flags_t   flags,    // Live flag register
  input  wire                   wbEn,
  input  wire cpuPkg::regIdx_t  wbRd,
  input  wire cpuPkg::word_t    wbData,
  output cpuPkg::idExReg_t      idExNext,
  output logic                  isBranch,
  output logic                  branchTaken,
  output cpuPkg::word_t         branchTarget,
  output logic                  decodeHlt,
  output cpuPkg::regIdx_t       src1,
  output cpuPkg::regIdx_t       src2,
  output logic                  storeSrc  // src2 is SW store data
);

  cpuPkg::opcode_t opcode;
  cpuPkg::regIdx_t regA;      // Bits [11:8], rd or rt
  cpuPkg::regIdx_t regB;      // Bits [7:4], rs
  cpuPkg::regIdx_t regC;      // Bits [3:0], rt
  cpuPkg::word_t   rdData1;
  cpuPkg::word_t   rdData2;
  cpuPkg::word_t   offsetLs;  // LW/SW byte offset
  cpuPkg::word_t   offsetBr;  // B byte offset
  logic            condMet;

  assign opcode   = ifId.instr[15:12];
  assign regA     = ifId.instr[11:8];
  assign regB     = ifId.instr[7:4];
  assign regC     = ifId.instr[3:0];
  assign offsetLs = {{11{ifId.instr[3]}}, ifId.instr[3:0], 1'b0};
  assign offsetBr = {{6{ifId.instr[8]}}, ifId.instr[8:0], 1'b0};

  registerFile i_registerFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddr1 (src1),
    .rdAddr2 (src2),
    .wrEn    (wbEn),
    .wrAddr  (wbRd),
    .wrData  (wbData),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  //////////////////////////////
  // Source registers
  //////////////////////////////
  always_comb begin
    src1     = '0;
    src2     = '0;
    storeSrc = 1'b0;
    if (ifId.valid) begin
      case (opcode)
        cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_XOR: begin
          src1 = regB;
          src2 = regC;
        end
        cpuPkg::OP_LW:  src1 = regB;  // Base only
        cpuPkg::OP_SW: begin
          src1     = regB;
          src2     = regA;            // Store data comes from rt
          storeSrc = 1'b1;
        end
        cpuPkg::OP_LHB: src1 = regA;  // Old rd supplies the low byte
        default: ;
      endcase
    end
  end

  // Branch condition against the live flags
  always_comb begin
    case (cpuPkg::cond_t'(ifId.instr[11:9]))
      cpuPkg::CC_NE:  condMet = ~flags.z;
      cpuPkg::CC_EQ:  condMet = flags.z;
      cpuPkg::CC_GT:  condMet = ~flags.z & ~flags.n;
      cpuPkg::CC_LT:  condMet = flags.n;
      cpuPkg::CC_GE:  condMet = flags.z | ~flags.n;
      cpuPkg::CC_LE:  condMet = flags.n | flags.z;
      cpuPkg::CC_OVF: condMet = flags.v;
      cpuPkg::CC_UN:  condMet = 1'b1;
      default:        condMet = 1'b0;
    endcase
  end

  assign isBranch     = ifId.valid && (opcode == cpuPkg::OP_B);
  assign branchTaken  = isBranch && condMet;
  assign branchTarget = ifId.pcNext + offsetBr;
  assign decodeHlt    = ifId.valid && (opcode == cpuPkg::OP_HLT);

  //////////////////////////////
  // Control build
  //////////////////////////////
  always_comb begin
    idExNext               = '0;       // Bubble unless a valid opcode fills it
    idExNext.pcNext        = ifId.pcNext;
    idExNext.ex.src1       = src1;
    idExNext.ex.src2       = src2;
    idExNext.ex.opA        = rdData1;
    idExNext.ex.opB        = rdData2;
    idExNext.mem.storeData = rdData2;
    if (ifId.valid) begin
      case (opcode)
        cpuPkg::OP_ADD, cpuPkg::OP_SUB: begin
          idExNext.ex.aluOp = (opcode == cpuPkg::OP_ADD) ? cpuPkg::ALU_ADD : cpuPkg::ALU_SUB;
          idExNext.ex.zEn   = 1'b1;
          idExNext.ex.nvEn  = 1'b1;
          idExNext.wb.rd       = regA;
          idExNext.wb.regWrite = 1'b1;
        end
        cpuPkg::OP_XOR: begin
          idExNext.ex.aluOp    = cpuPkg::ALU_XOR;
          idExNext.ex.zEn      = 1'b1; // Z only
          idExNext.wb.rd       = regA;
          idExNext.wb.regWrite = 1'b1;
        end
        cpuPkg::OP_LW: begin
          idExNext.ex.aluOp     = cpuPkg::ALU_ADD; // Address = rs + offset
          idExNext.ex.useImm    = 1'b1;
          idExNext.ex.imm       = offsetLs;
          idExNext.mem.memEnable = 1'b1;
          idExNext.wb.rd        = regA;
          idExNext.wb.regWrite  = 1'b1;
          idExNext.wb.memToReg  = 1'b1;
        end
        cpuPkg::OP_SW: begin
          idExNext.ex.aluOp      = cpuPkg::ALU_ADD;
          idExNext.ex.useImm     = 1'b1;
          idExNext.ex.imm        = offsetLs;
          idExNext.mem.memEnable = 1'b1;
          idExNext.mem.memWrite  = 1'b1;
          idExNext.wb.rd         = regA; // Key for MEM-to-MEM forward
        end
        cpuPkg::OP_LLB, cpuPkg::OP_LHB: begin
          idExNext.ex.aluOp    = cpuPkg::ALU_PASS;
          idExNext.ex.useImm   = 1'b1;
          // LLB sign-extends, LHB places the byte high and keeps rd's low byte
          idExNext.ex.imm      = (opcode == cpuPkg::OP_LLB) ?
                                 {{8{ifId.instr[7]}}, ifId.instr[7:0]} :
                                 {ifId.instr[7:0], 8'h00};
          idExNext.wb.rd       = regA;
          idExNext.wb.regWrite = 1'b1;
        end
        cpuPkg::OP_PCS: begin
          idExNext.ex.aluOp    = cpuPkg::ALU_PASS; // ALU result also carries PC+2
          idExNext.ex.useImm   = 1'b1;
          idExNext.ex.imm      = ifId.pcNext;
          idExNext.wb.rd       = regA;
          idExNext.wb.regWrite = 1'b1;
          idExNext.wb.pcs      = 1'b1;
        end
        cpuPkg::OP_HLT: idExNext.wb.hlt = 1'b1;
        default: ; // B resolves here and sends nothing down
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/fetch.sv ====
`default_nettype none

module fetch (
  input  wire                clk,
  input  wire                rstN,
  input  wire                pcStall,      // Load-use or flag hazard
  input  wire                decodeHlt,    // HLT sitting in decode
  input  wire                branchTaken,
  input  wire cpuPkg::word_t branchTarget,
  output cpuPkg::word_t      pc,
  output cpuPkg::word_t      pcNext
);

  logic halted; // Sticky once HLT has been decoded

  assign pcNext = pc + 16'd2; // Sequential fetch address

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      if (decodeHlt) halted <= 1'b1;
      // PC already points past HLT, so freezing here keeps HLT+2
      if (!(halted || decodeHlt || pcStall)) begin
        pc <= branchTaken ? branchTarget : pcNext; // Redirect wins over PC+2
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
  input  wire cpuPkg::regIdx_t  src1,
  input  wire cpuPkg::regIdx_t  src2,
  input  wire                   storeSrc,    // src2 only feeds SW data
  input  wire                   isBranch,
  input  wire                   branchTaken,
  input  wire cpuPkg::wbCtrl_t  idExWb,
  input  wire cpuPkg::memCtrl_t idExMem,
  input  wire                   idExZEn,
  input  wire                   idExNvEn,
  output logic                  pcStall,
  output logic                  ifIdStall,
  output logic                  ifFlush,
  output logic                  idFlush
);

  logic loadUse; // LW result needed by the instruction in decode
  logic flagHaz; // B waits for flags still in EX
  logic stall;

  always_comb begin
    // SW store data is covered by MEM-to-MEM forwarding instead
    loadUse = idExWb.regWrite && idExMem.memEnable && !idExMem.memWrite &&
              (idExWb.rd != '0) &&
              ((src1 == idExWb.rd) || ((src2 == idExWb.rd) && !storeSrc));
    flagHaz = isBranch && (idExZEn || idExNvEn);
  end

  assign stall     = loadUse || flagHaz;
  assign pcStall   = stall;
  assign ifIdStall = stall;
  assign idFlush   = stall;                  // Bubble into ID/EX
  assign ifFlush   = branchTaken && !stall;  // Drop the fall-through fetch

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`default_nettype none

module registerFile (
  input  wire                  clk,
  input  wire                  rstN,
  input  wire cpuPkg::regIdx_t rdAddr1,
  input  wire cpuPkg::regIdx_t rdAddr2,
  input  wire                  wrEn,
  input  wire cpuPkg::regIdx_t wrAddr,
  input  wire cpuPkg::word_t   wrData,
  output cpuPkg::word_t        rdData1,
  output cpuPkg::word_t        rdData2
);

  cpuPkg::word_t regs [16]; // r0 is never written

  // One read port, with r0 forced to zero and write-through bypass
  function automatic cpuPkg::word_t readPort(input cpuPkg::regIdx_t addr);
    if (addr == '0) return '0;
    if (wrEn && (addr == wrAddr)) return wrData; // Same-cycle write is visible
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  always_comb begin
    rdData1 = readPort(rdAddr1);
  end

  always_comb begin
    rdData2 = readPort(rdAddr2);
  end

endmodule

`default_nettype wire

// ==== verification/cpuStimulus.hex ====
// Program length, program words, store count, address and data pairs, halt PC
// Every value is one 16-bit hex word
0022            // 34 program words
// Arithmetic with forwarding
A134 B112       // LLB and LHB r1 build 1234
A205            // LLB r2 becomes 0005
0312            // ADD r3 = r1 + r2 gives 1239
1431            // SUB r4 = r3 - r1 gives 0005
2543            // XOR r5 = r4 ^ r3 gives 123C
9300 9401 9502  // SW r3, r4, r5 to 0000, 0002, 0004
// Saturation and flag branches
A6FF B67F       // r6 becomes 7FFF
0766            // ADD r7 = r6 + r6 saturates with V set
CC01            // B ovf taken over the next word
910F            // Flushed store to FFFE
9703            // SW r7 to 0006
A800 B880       // r8 becomes 8000
1981            // SUB r9 = r8 - r1 saturates with N and V set
9904            // SW r9 to 0008
C601            // B lt taken
910F            // Skipped
C201            // B eq with Z clear falls through
9205            // SW r2 to 000A
2A11            // XOR r10 = r1 ^ r1 sets Z
C201            // B eq taken
910F            // Skipped
// Load-use and MEM-to-MEM
8B00            // LW r11 from 0000
0CB2            // ADD r12 = r11 + r2 gives 123E
9C06            // SW r12 to 000C
8D02            // LW r13 from 0004
9D07            // SW r13 to 000E right behind the load
// PCS and halt
EE00            // PCS r14 at 003E gives 0040
9EE0            // SW r14 to address r14
F000            // HLT at 0042
0009            // Expected store count
0000 1239
0002 0005
0004 123C
0006 7FFF
0008 8000
000A 0005
000C 123E
000E 123C
0040 0040
0044            // PC frozen after HLT

// ==== verification/cpuTb.sv ====
`default_nettype none

module cpuTb;

  logic          clk = 1'b0;
  logic          rstN = 1'b0;          // Held low from time zero
  cpuPkg::word_t instr = '0;
  cpuPkg::word_t memReadData = '0;
  cpuPkg::word_t pc;
  cpuPkg::word_t memAddr;
  cpuPkg::word_t memWriteData;
  logic          memEnable;
  logic          memWrite;
  logic          hlt;

  cpuPkg::word_t stim    [0:127];     // Raw image of the stimulus file
  cpuPkg::word_t progMem [0:255];     // Instruction memory, word indexed
  cpuPkg::word_t dataMem [0:255];     // Data memory, word indexed
  cpuPkg::word_t expAddr [0:63];      // Expected stores in program order
  cpuPkg::word_t expData [0:63];
  cpuPkg::word_t expHaltPc;
  int            progLen = 0;
  int            expCount = 0;
  int            storeIdx = 0;         // Next expected store
  int            cycleCount = 0;
  int            timeoutLimit = 1000;  // Recomputed once the program is loaded

  cpu i_cpu (
    .clk          (clk),
    .rstN         (rstN),
    .instr        (instr),
    .memReadData  (memReadData),
    .pc           (pc),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memEnable    (memEnable),
    .memWrite     (memWrite),
    .hlt          (hlt)
  );

  always #50 clk = ~clk; // 100 unit period

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input cpuPkg::word_t expected,
                           input cpuPkg::word_t actual);
    if (actual !== expected) begin
      reportFailure($sformatf("** Error: %s: expected %h, actual %h",
                              name, expected, actual));
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      reportFailure($sformatf("** Error: %s: expected %b, actual %b",
                              name, expected, actual));
    end
  endtask

  function automatic cpuPkg::word_t stimWord(input int pos);
    return stim[pos[6:0]];
  endfunction

  //////////////////////////////
  // Memory models
  //////////////////////////////
  always @(negedge clk) begin
    // Store sampled mid-cycle, it lands at the next rising edge
    if (rstN && memEnable && memWrite) begin
      if (storeIdx >= expCount) begin
        reportFailure($sformatf("unexpected store of %h to address %h",
                                memWriteData, memAddr));
      end else begin
        checkWord($sformatf("store %0d address", storeIdx), expAddr[storeIdx[5:0]], memAddr);
        checkWord($sformatf("store %0d data", storeIdx), expData[storeIdx[5:0]], memWriteData);
        dataMem[memAddr[8:1]] = memWriteData;
        storeIdx = storeIdx + 1;
      end
    end
    // Past the program end the fetch sees HLT
    if (int'(pc >> 1) < progLen) instr = progMem[pc[8:1]];
    else instr = {cpuPkg::OP_HLT, 12'h000};
    memReadData = dataMem[memAddr[8:1]]; // Read data for this cycle's access
  end

  // Cycle budget counted from reset release
  always @(posedge clk) begin
    if (rstN) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > timeoutLimit) begin
        reportFailure($sformatf("timeout, hlt not seen within %0d cycles", timeoutLimit));
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    $readmemh("verification/cpuStimulus.hex", stim);
    if ($isunknown(stim[0])) reportFailure("stimulus file missing or empty");
    progLen = int'(stim[0]);
    expCount = int'(stimWord(progLen + 1));
    if (progLen < 1 || progLen > 200 || expCount > 64 ||
        progLen + 3 + 2 * expCount > 128) begin
      reportFailure("stimulus file layout does not fit the testbench arrays");
    end
    for (int i = 0; i < progLen; i++) begin
      progMem[i[7:0]] = stimWord(i + 1);
    end
    for (int k = 0; k < expCount; k++) begin
      expAddr[k[5:0]] = stimWord(progLen + 2 + 2 * k); // Address then data
      expData[k[5:0]] = stimWord(progLen + 3 + 2 * k);
    end
    for (int i = 0; i < 256; i++) begin
      dataMem[i[7:0]] = '0;            // Data memory starts cleared
    end
    expHaltPc = stimWord(progLen + 2 + 2 * expCount);
    timeoutLimit = 4 * progLen + 50;

    repeat (5) @(negedge clk);         // Five reset cycles
    rstN = 1'b1;
    checkWord("pc after reset", 16'h0000, pc);
    checkFlag("hlt after reset", 1'b0, hlt);
    checkFlag("memEnable after reset", 1'b0, memEnable);
    checkFlag("memWrite after reset", 1'b0, memWrite);

    while (hlt !== 1'b1) @(negedge clk);
    checkWord("halt pc", expHaltPc, pc);
    repeat (5) @(negedge clk);         // Quiet window, any store here is extra
    checkFlag("hlt held", 1'b1, hlt);
    checkWord("pc held after halt", expHaltPc, pc);

    if (storeIdx == expCount) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      reportFailure($sformatf("halted after %0d of %0d expected stores",
                              storeIdx, expCount));
    end
  end

endmodule

`default_nettype wire
